// ==== include/lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// ----------------------------------------------------------------------
// Data widths
// ----------------------------------------------------------------------

`define LCD_CMD_WIDTH       32
`define LCD_DATA_WIDTH      16
// RS bit sits above the data bits
`define LCD_ENTRY_WIDTH     17

// FIFO depths
`define LCD_CMD_FIFO_DEPTH  8
`define LCD_BUS_FIFO_DEPTH  4

// Printer command fields
`define LCD_OP_MSB          31
`define LCD_OP_LSB          28
`define LCD_COUNT_MSB       27
`define LCD_COUNT_LSB       16

// Write strobe timing in clock cycles
`define LCD_WR_LOW_CYCLES   2
`define LCD_WR_HIGH_CYCLES  2

`endif

// ==== logic/lcdPkg.sv ====
package lcdPkg;

    // ----------------------------------------------------------------------
    // Printer command opcodes
    // ----------------------------------------------------------------------

    // Codes outside this set are popped and dropped
    typedef enum logic [3:0] {
        OpRegSelect = 4'd1,
        OpPixel     = 4'd2,
        OpFill      = 4'd3
    } printerOp_t;

    // Pixel engine FSM
    typedef enum logic {
        EngIdle,
        EngFill
    } engineState_t;

    // Bus writer FSM
    typedef enum logic [1:0] {
        BusIdle,
        BusStrobeLow,
        BusStrobeHigh
    } busState_t;

    // Bit 16 is RS, bits 15..0 go onto the LCD data bus
    typedef logic [16:0] busEntry_t;

endpackage

// ==== logic/syncFifo.sv ====
module syncFifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             RSTn,
    input  logic             inValid,
    input  logic [WIDTH-1:0] inData,
    output logic             inReady,
    output logic             outValid,
    output logic [WIDTH-1:0] outData,
    input  logic             outReady
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  count;
    logic             push;
    logic             pop;

    // Flags come straight from the registered occupancy
    assign inReady  = (count != CntW'(DEPTH));
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];

    assign push = inValid && inReady;
    assign pop  = outValid && outReady;

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    occupancyBound: assert property (@(posedge clk) disable iff (!RSTn)
        count <= CntW'(DEPTH))
        else $error("syncFifo occupancy above DEPTH");

    // An empty count means the read pointer has caught up with the write pointer
    noUnderflow: assert property (@(posedge clk) disable iff (!RSTn)
        (count == '0) |-> (rdPtr == wrPtr))
        else $error("syncFifo occupancy underflow");

endmodule

// ==== logic/pixelEngine.sv ====
`include "lcd_consts.svh"

module pixelEngine import lcdPkg::*; (
    input  logic                      clk,
    input  logic                      RSTn,
    input  logic                      cmdValid,
    input  logic [`LCD_CMD_WIDTH-1:0] cmdData,
    output logic                      cmdReady,
    output logic                      entryValid,
    output busEntry_t                 entry,
    input  logic                      entryReady
);

    localparam int CountW = `LCD_COUNT_MSB - `LCD_COUNT_LSB + 1;

    engineState_t              state;
    logic [CountW-1:0]         fillCount;
    printerOp_t                op;
    logic [CountW-1:0]         cmdCount;
    logic [`LCD_DATA_WIDTH-1:0] colour;
    logic                      pop;
    logic                      loadEntry;
    busEntry_t                 newEntry;

    // ----------------------------------------------------------------------
    // Command decode
    // ----------------------------------------------------------------------

    assign op       = printerOp_t'(cmdData[`LCD_OP_MSB:`LCD_OP_LSB]);
    assign cmdCount = cmdData[`LCD_COUNT_MSB:`LCD_COUNT_LSB];
    assign colour   = cmdData[`LCD_DATA_WIDTH-1:0];

    // Pop only when idle and the output slot frees up this cycle
    assign cmdReady = (state == EngIdle) && (!entryValid || entryReady);
    assign pop      = cmdValid && cmdReady;

    always_comb begin
        loadEntry = 1'b0;
        newEntry  = {1'b1, colour};
        case (op)
            OpRegSelect: begin
                loadEntry = 1'b1;
                // Register index in the low byte with RS low
                newEntry  = {1'b0, {(`LCD_DATA_WIDTH - 8){1'b0}}, cmdData[7:0]};
            end
            OpPixel: begin
                loadEntry = 1'b1;
            end
            OpFill: begin
                loadEntry = (cmdCount != '0);
            end
            default: begin
                loadEntry = 1'b0;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state      <= EngIdle;
            entryValid <= 1'b0;
            fillCount  <= '0;
        end else begin
            case (state)
                EngIdle: begin
                    if (pop) begin
                        entryValid <= loadEntry;
                        if (op == OpFill && loadEntry) begin
                            state     <= EngFill;
                            fillCount <= cmdCount;
                        end
                    end else if (entryReady) begin
                        entryValid <= 1'b0;
                    end
                end
                EngFill: begin
                    // Same entry is offered again until the run is done
                    if (entryReady) begin
                        if (fillCount == CountW'(1)) begin
                            state      <= EngIdle;
                            entryValid <= 1'b0;
                            fillCount  <= '0;
                        end else begin
                            fillCount <= fillCount - 1'b1;
                        end
                    end
                end
                default: state <= EngIdle;
            endcase
        end
    end

    // Output entry
    always_ff @(posedge clk) begin
        if (pop && loadEntry) begin
            entry <= newEntry;
        end
    end

    fillCountLive: assert property (@(posedge clk) disable iff (!RSTn)
        (state == EngFill) |-> (fillCount != '0))
        else $error("pixelEngine in fill with zero count");

endmodule

// ==== logic/lcdBusWriter.sv ====
`include "lcd_consts.svh"

module lcdBusWriter import lcdPkg::*; (
    input  logic                       clk,
    input  logic                       RSTn,
    input  logic                       entryValid,
    input  busEntry_t                  entry,
    output logic                       entryReady,
    output logic                       lcdCs,
    output logic                       lcdRs,
    output logic                       lcdWr,
    output logic [`LCD_DATA_WIDTH-1:0] lcdData
);

    localparam logic [3:0] LowLast  = 4'(`LCD_WR_LOW_CYCLES - 1);
    localparam logic [3:0] HighLast = 4'(`LCD_WR_HIGH_CYCLES - 1);

    busState_t  state;
    logic [3:0] phase;
    logic       accept;

    // Next word may start on the last cycle of the high phase
    assign entryReady = (state == BusIdle) ||
                        (state == BusStrobeHigh && phase == HighLast);
    assign accept     = entryValid && entryReady;

    // ----------------------------------------------------------------------
    // Strobe sequencing
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state <= BusIdle;
            phase <= '0;
            lcdCs <= 1'b1;
            lcdWr <= 1'b1;
        end else begin
            case (state)
                BusIdle: begin
                    if (accept) begin
                        state <= BusStrobeLow;
                        phase <= '0;
                        lcdCs <= 1'b0;
                        lcdWr <= 1'b0;
                    end
                end
                BusStrobeLow: begin
                    if (phase == LowLast) begin
                        // LCD latches on this rising edge
                        state <= BusStrobeHigh;
                        phase <= '0;
                        lcdWr <= 1'b1;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                BusStrobeHigh: begin
                    if (phase != HighLast) begin
                        phase <= phase + 1'b1;
                    end else if (accept) begin
                        // Chip select stays low for a back to back write
                        state <= BusStrobeLow;
                        phase <= '0;
                        lcdWr <= 1'b0;
                    end else begin
                        state <= BusIdle;
                        phase <= '0;
                        lcdCs <= 1'b1;
                    end
                end
                default: state <= BusIdle;
            endcase
        end
    end

    // RS and data held for the whole word
    always_ff @(posedge clk) begin
        if (accept) begin
            {lcdRs, lcdData} <= entry;
        end
    end

    wrInsideCs: assert property (@(posedge clk) disable iff (!RSTn)
        !lcdWr |-> !lcdCs)
        else $error("lcdWr low while lcdCs high");

endmodule

// ==== logic/lcdPrinterTop.sv ====
`include "lcd_consts.svh"

module lcdPrinterTop import lcdPkg::*; (
    input  logic                       clk,
    input  logic                       RSTn,
    input  logic                       cmdValid,
    input  logic [`LCD_CMD_WIDTH-1:0]  cmdData,
    output logic                       cmdReady,
    output logic                       lcdCs,
    output logic                       lcdRs,
    output logic                       lcdWr,
    output logic [`LCD_DATA_WIDTH-1:0] lcdData
);

    // ----------------------------------------------------------------------
    // Command FIFO
    // ----------------------------------------------------------------------

    logic                      cmdFifoValid;
    logic [`LCD_CMD_WIDTH-1:0] cmdFifoData;
    logic                      engineCmdReady;

    syncFifo #(
        .WIDTH (`LCD_CMD_WIDTH),
        .DEPTH (`LCD_CMD_FIFO_DEPTH)
    ) cmdFifo (
        .clk      (clk),
        .RSTn     (RSTn),
        .inValid  (cmdValid),
        .inData   (cmdData),
        .inReady  (cmdReady),
        .outValid (cmdFifoValid),
        .outData  (cmdFifoData),
        .outReady (engineCmdReady)
    );

    // ----------------------------------------------------------------------
    // Pixel engine
    // ----------------------------------------------------------------------

    logic      engineValid;
    busEntry_t engineEntry;
    logic      busFifoReady;

    pixelEngine pixelEngine (
        .clk        (clk),
        .RSTn       (RSTn),
        .cmdValid   (cmdFifoValid),
        .cmdData    (cmdFifoData),
        .cmdReady   (engineCmdReady),
        .entryValid (engineValid),
        .entry      (engineEntry),
        .entryReady (busFifoReady)
    );

    // ----------------------------------------------------------------------
    // Bus FIFO and LCD writer
    // ----------------------------------------------------------------------

    logic      busValid;
    busEntry_t busEntry;
    logic      writerReady;

    syncFifo #(
        .WIDTH (`LCD_ENTRY_WIDTH),
        .DEPTH (`LCD_BUS_FIFO_DEPTH)
    ) busFifo (
        .clk      (clk),
        .RSTn     (RSTn),
        .inValid  (engineValid),
        .inData   (engineEntry),
        .inReady  (busFifoReady),
        .outValid (busValid),
        .outData  (busEntry),
        .outReady (writerReady)
    );

    lcdBusWriter lcdBusWriter (
        .clk        (clk),
        .RSTn       (RSTn),
        .entryValid (busValid),
        .entry      (busEntry),
        .entryReady (writerReady),
        .lcdCs      (lcdCs),
        .lcdRs      (lcdRs),
        .lcdWr      (lcdWr),
        .lcdData    (lcdData)
    );

endmodule

// ==== bench/lcdPrinterTb.sv ====
`include "lcd_consts.svh"

module lcdPrinterTb;

    // Unused stimulus slots carry flag nibble F
    localparam logic [3:0] EmptyFlag = 4'hF;

    logic                       clk;
    logic                       RSTn;
    logic                       cmdValid;
    logic [`LCD_CMD_WIDTH-1:0]  cmdData;
    logic                       cmdReady;
    logic                       lcdCs;
    logic                       lcdRs;
    logic                       lcdWr;
    logic [`LCD_DATA_WIDTH-1:0] lcdData;

    logic [35:0] stimMem [0:127];
    logic [35:0] cmdList [$];
    logic [16:0] expList [$];

    int          seed = 48832;
    int          errorCount = 0;
    int          checkCount = 0;
    int          gotCount = 0;
    int          lowCycles = 0;
    logic        prevWr = 1'b1;
    logic [16:0] heldEntry = '0;
    logic        sawFull = 1'b0;
    logic        timedOut = 1'b0;

    lcdPrinterTop i_lcdPrinterTop (
        .clk      (clk),
        .RSTn     (RSTn),
        .cmdValid (cmdValid),
        .cmdData  (cmdData),
        .cmdReady (cmdReady),
        .lcdCs    (lcdCs),
        .lcdRs    (lcdRs),
        .lcdWr    (lcdWr),
        .lcdData  (lcdData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // -------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            $display("ERROR: time %0t %s got %h expected %h", $time, name, got, expected);
            errorCount++;
        end
    endtask

    task automatic checkResetState();
        checkValue("lcdCs", 32'(lcdCs), 32'd1);
        checkValue("lcdWr", 32'(lcdWr), 32'd1);
        checkValue("cmdReady", 32'(cmdReady), 32'd1);
    endtask

    // Commands below address 0x40, expected entries from 0x40 on
    task automatic loadStimulus();
        int k;
        for (k = 0; k < 128; k++) begin
            stimMem[k] = {EmptyFlag, 32'(k)};
        end
        $readmemh("bench/lcd_stim.txt", stimMem);
        k = 0;
        while (k < 64 && stimMem[k][35:32] != EmptyFlag) begin
            cmdList.push_back(stimMem[k]);
            k++;
        end
        k = 64;
        while (k < 128 && stimMem[k][35:32] != EmptyFlag) begin
            expList.push_back(stimMem[k][16:0]);
            k++;
        end
        if (cmdList.size() == 0 || expList.size() == 0) begin
            $display("Stimulus file bench/lcd_stim.txt holds no commands or no expected writes");
            errorCount++;
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic sendCommand(input logic [`LCD_CMD_WIDTH-1:0] cmd);
        int waitCycles;
        waitCycles = 0;
        cmdValid = 1'b1;
        cmdData  = cmd;
        while (!cmdReady && waitCycles < 200) begin
            sawFull = 1'b1;
            @(negedge clk);
            waitCycles++;
        end
        if (!cmdReady) begin
            $display("Command %h was not accepted within 200 cycles", cmd);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            // Taken on the rising edge in between
            @(negedge clk);
        end
        cmdValid = 1'b0;
    endtask

    // -------------------------------------------------------------------
    // LCD bus monitor
    // -------------------------------------------------------------------

    always @(negedge clk) begin
        if (RSTn) begin
            if (!lcdWr) begin
                checkValue("lcdCs", 32'(lcdCs), 32'd0);
                if (prevWr) begin
                    heldEntry <= {lcdRs, lcdData};
                    lowCycles <= 1;
                end else begin
                    checkValue("lcdRs/lcdData hold", 32'({lcdRs, lcdData}), 32'(heldEntry));
                    lowCycles <= lowCycles + 1;
                end
            end else if (!prevWr) begin
                // lcdWr rose on the last edge, the LCD latched this word
                checkValue("lcdWr low cycles", 32'(lowCycles), 32'(`LCD_WR_LOW_CYCLES));
                if (gotCount < expList.size()) begin
                    checkValue("lcdRs/lcdData", 32'({lcdRs, lcdData}), 32'(expList[gotCount]));
                end else begin
                    $display("Unexpected LCD write %h after the expected list ran out",
                             {lcdRs, lcdData});
                    errorCount++;
                end
                gotCount <= gotCount + 1;
            end
            prevWr <= lcdWr;
        end
    end

    // -------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------

    initial begin
        int idx;
        int gap;
        int waitCycles;
        RSTn     = 1'b0;
        cmdValid = 1'b0;
        cmdData  = '0;
        loadStimulus();

        repeat (4) begin
            @(negedge clk);
            checkResetState();
        end
        RSTn = 1'b1;
        @(negedge clk);
        checkResetState();

        for (idx = 0; idx < cmdList.size() && !timedOut; idx++) begin
            if (cmdList[idx][35:32] != 4'h0) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
            end
            sendCommand(cmdList[idx][31:0]);
        end

        if (!timedOut) begin
            waitCycles = 0;
            while (gotCount < expList.size() && waitCycles < 5000) begin
                @(negedge clk);
                waitCycles++;
            end
            if (gotCount < expList.size()) begin
                $display("Only %0d of %0d LCD writes arrived within 5000 cycles",
                         gotCount, expList.size());
                errorCount++;
            end else begin
                // Any extra write shows up in this quiet window
                repeat (12) @(negedge clk);
                checkValue("lcdCs idle", 32'(lcdCs), 32'd1);
                checkValue("cmdReady fell", 32'(sawFull), 32'd1);
            end
        end

        $display("LCD writes: %0d, checks: %0d, errors: %0d", gotCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/lcd_stim.txt ====
// Commands from @00: first hex digit 1 asks for a random gap, then the 32-bit command
// Expected writes from @40: 17-bit {RS, data}, in the order they reach the LCD
@00
11fffab2c   // register select, count bits ignored, low byte only
12000f800   // single pixel
0300307e0   // fill of 3
130001234   // fill of 0
070005555   // unknown opcode
100001111   // opcode 0
010000036   // register select
03008001f   // fill of 8 stalls the engine
02000a001   // gapless burst fills the command FIFO
02000a002
02000a003
02000a004
02000a005
02000a006
02000a007
02000a008
02000a009
@40
0002c
1f800
107e0 107e0 107e0
00036
1001f 1001f 1001f 1001f
1001f 1001f 1001f 1001f
1a001 1a002 1a003
1a004 1a005 1a006
1a007 1a008 1a009

// ==== vlog.f ====
+incdir+include
logic/lcdPkg.sv
logic/syncFifo.sv
logic/pixelEngine.sv
logic/lcdBusWriter.sv
logic/lcdPrinterTop.sv
bench/lcdPrinterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LCD printer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module lcdPrinterTb -f vlog.f -Mdir obj_dir

output=$(./obj_dir/VlcdPrinterTb)
echo "$output"

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
else
    exit 1
fi
